// File: verilog/pulp_params.svh
// widths, memory sizes and address map of the PULP memory-side data path
`ifndef PULP_PARAMS_SVH
`define PULP_PARAMS_SVH

// bus and transaction widths
`define PULP_ADDR_W      32
`define PULP_DATA_W      128
`define PULP_PERIPH_DW   64
`define PULP_ID_W        4

// L2 memory, 64 words of 128 bits
`define PULP_L2_WORDS    64
`define PULP_L2_BASE     32'h0000_0000

// peripheral register block
`define PULP_PERIPH_BASE 32'h1000_0000
`define PULP_PERIPH_REGS 8

// requests in flight inside the SoC bus
`define PULP_ROUTE_DEPTH 2

`endif

// File: verilog/pulp_pkg.sv
// shared vector types and FSM encodings of the PULP data path
`include "pulp_params.svh"

package pulp_pkg;

  // bus side
  typedef logic [`PULP_ADDR_W-1:0]   addr_t;
  typedef logic [`PULP_DATA_W-1:0]   data_t;
  typedef logic [`PULP_DATA_W/8-1:0] strb_t;
  typedef logic [`PULP_ID_W-1:0]     id_t;

  // peripheral side after the width converter
  typedef logic [`PULP_PERIPH_DW-1:0]   periph_data_t;
  typedef logic [`PULP_PERIPH_DW/8-1:0] periph_strb_t;

  // target selected by the address decoder
  typedef enum logic [1:0] {
    ROUTE_L2,
    ROUTE_PERIPH,
    ROUTE_ERR
  } route_t;

  // width converter states
  typedef enum logic [1:0] {
    DWC_IDLE,
    DWC_LO,
    DWC_HI,
    DWC_RESP
  } dwc_state_t;

endpackage

// File: verilog/l2_mem.sv
// L2 word memory with byte strobes and a registered response
`timescale 1ns/100ps
`include "pulp_params.svh"

module l2_mem import pulp_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_we_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  input  strb_t req_strb_i,
  input  id_t   req_id_i,
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output id_t   rsp_id_o
);

  localparam int unsigned IDX_W = $clog2(`PULP_L2_WORDS);

  data_t            mem_q [`PULP_L2_WORDS];
  logic [IDX_W-1:0] idx;
  logic             req_fire;
  logic             rsp_valid_q;
  data_t            rsp_rdata_q;
  id_t              rsp_id_q;

  // byte address to word index
  assign idx         = req_addr_i[4 +: IDX_W];
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (req_fire && req_we_i) begin
      for (int b = 0; b < `PULP_DATA_W / 8; b++) begin
        if (req_strb_i[b]) begin
          mem_q[idx][b*8 +: 8] <= req_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // write responses return zero data
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_rdata_q <= req_we_i ? '0 : mem_q[idx];
      rsp_id_q    <= req_id_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_id_o    = rsp_id_q;

endmodule

// File: verilog/periph_dwc.sv
// data width converter from the 128-bit bus to the 64-bit peripheral port
`timescale 1ns/100ps
`include "pulp_params.svh"

module periph_dwc import pulp_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  // 128-bit slave side
  input  logic         req_valid_i,
  output logic         req_ready_o,
  input  logic         req_we_i,
  input  addr_t        req_addr_i,
  input  data_t        req_wdata_i,
  input  strb_t        req_strb_i,
  input  id_t          req_id_i,
  output logic         rsp_valid_o,
  input  logic         rsp_ready_i,
  output data_t        rsp_rdata_o,
  output id_t          rsp_id_o,
  // 64-bit master side
  output logic         p_req_valid_o,
  input  logic         p_req_ready_i,
  output logic         p_req_we_o,
  output addr_t        p_req_addr_o,
  output periph_data_t p_req_wdata_o,
  output periph_strb_t p_req_strb_o,
  input  logic         p_rsp_valid_i,
  output logic         p_rsp_ready_o,
  input  periph_data_t p_rsp_rdata_i
);

  localparam int unsigned PDW = `PULP_PERIPH_DW;

  dwc_state_t state_q;
  logic       beat_sent_q;
  logic       in_beat;
  logic       hi_beat;
  logic       p_rsp_fire;
  logic       we_q;
  addr_t      addr_q;
  data_t      wdata_q;
  strb_t      strb_q;
  id_t        id_q;
  data_t      rdata_q;

  assign in_beat    = (state_q == DWC_LO) || (state_q == DWC_HI);
  assign hi_beat    = (state_q == DWC_HI);
  assign p_rsp_fire = p_rsp_valid_i && p_rsp_ready_o;

  assign req_ready_o   = (state_q == DWC_IDLE);
  // each beat is one request, then wait for its response
  assign p_req_valid_o = in_beat && !beat_sent_q;
  assign p_rsp_ready_o = in_beat && beat_sent_q;
  assign p_req_we_o    = we_q;
  assign p_req_addr_o  = {addr_q[`PULP_ADDR_W-1:4], hi_beat, 3'b000};
  assign p_req_wdata_o = hi_beat ? wdata_q[PDW +: PDW] : wdata_q[0 +: PDW];
  assign p_req_strb_o  = hi_beat ? strb_q[PDW/8 +: PDW/8] : strb_q[0 +: PDW/8];

  assign rsp_valid_o = (state_q == DWC_RESP);
  assign rsp_rdata_o = rdata_q;
  assign rsp_id_o    = id_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= DWC_IDLE;
      beat_sent_q <= 1'b0;
    end else begin
      case (state_q)
        DWC_IDLE: begin
          if (req_valid_i) begin
            state_q <= DWC_LO;
          end
        end
        DWC_LO, DWC_HI: begin
          if (p_req_valid_o && p_req_ready_i) begin
            beat_sent_q <= 1'b1;
          end
          if (p_rsp_fire) begin
            beat_sent_q <= 1'b0;
            state_q     <= hi_beat ? DWC_RESP : DWC_HI;
          end
        end
        DWC_RESP: begin
          if (rsp_ready_i) begin
            state_q <= DWC_IDLE;
          end
        end
        default: state_q <= DWC_IDLE;
      endcase
    end
  end

  // request latch and read data assembly
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      we_q    <= req_we_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
      strb_q  <= req_strb_i;
      id_q    <= req_id_i;
    end
    if (p_rsp_fire) begin
      if (hi_beat) begin
        rdata_q[PDW +: PDW] <= p_rsp_rdata_i;
      end else begin
        rdata_q[0 +: PDW] <= p_rsp_rdata_i;
      end
    end
  end

endmodule

// File: verilog/soc_peripherals.sv
// peripheral register file with byte strobes and a registered response
`timescale 1ns/100ps
`include "pulp_params.svh"

module soc_peripherals import pulp_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  input  logic         req_we_i,
  input  addr_t        req_addr_i,
  input  periph_data_t req_wdata_i,
  input  periph_strb_t req_strb_i,
  output logic         rsp_valid_o,
  input  logic         rsp_ready_i,
  output periph_data_t rsp_rdata_o
);

  localparam int unsigned IDX_W = $clog2(`PULP_PERIPH_REGS);

  periph_data_t     regs_q [`PULP_PERIPH_REGS];
  logic [IDX_W-1:0] idx;
  logic             req_fire;
  logic             rsp_valid_q;
  periph_data_t     rsp_rdata_q;

  // register select from address bits 5:3
  assign idx         = req_addr_i[3 +: IDX_W];
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (req_fire && req_we_i) begin
      for (int b = 0; b < `PULP_PERIPH_DW / 8; b++) begin
        if (req_strb_i[b]) begin
          regs_q[idx][b*8 +: 8] <= req_wdata_i[b*8 +: 8];
        end
      end
    end
    if (req_fire) begin
      rsp_rdata_q <= req_we_i ? '0 : regs_q[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;

endmodule

// File: verilog/soc_bus.sv
// SoC bus with address decode, route order FIFO, error responder and response mux
`timescale 1ns/100ps
`include "pulp_params.svh"

module soc_bus import pulp_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  // host side
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_we_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  input  strb_t req_strb_i,
  input  id_t   req_id_i,
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output id_t   rsp_id_o,
  output logic  rsp_err_o,
  // L2 memory
  output logic  l2_req_valid_o,
  input  logic  l2_req_ready_i,
  output logic  l2_req_we_o,
  output addr_t l2_req_addr_o,
  output data_t l2_req_wdata_o,
  output strb_t l2_req_strb_o,
  output id_t   l2_req_id_o,
  input  logic  l2_rsp_valid_i,
  output logic  l2_rsp_ready_o,
  input  data_t l2_rsp_rdata_i,
  input  id_t   l2_rsp_id_i,
  // peripherals, through the width converter
  output logic  periph_req_valid_o,
  input  logic  periph_req_ready_i,
  output logic  periph_req_we_o,
  output addr_t periph_req_addr_o,
  output data_t periph_req_wdata_o,
  output strb_t periph_req_strb_o,
  output id_t   periph_req_id_o,
  input  logic  periph_rsp_valid_i,
  output logic  periph_rsp_ready_o,
  input  data_t periph_rsp_rdata_i,
  input  id_t   periph_rsp_id_i
);

  localparam int unsigned DEPTH = `PULP_ROUTE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam addr_t L2_BYTES = addr_t'(`PULP_L2_WORDS * (`PULP_DATA_W / 8));
  localparam addr_t PERIPH_BYTES = addr_t'(`PULP_PERIPH_REGS * (`PULP_PERIPH_DW / 8));

  addr_t            l2_off;
  addr_t            periph_off;
  route_t           req_route;
  route_t           head;
  route_t           fifo_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             fifo_full;
  logic             fifo_empty;
  logic             push;
  logic             pop;
  logic             target_ready;
  logic             sel_valid;
  logic             err_valid_q;
  logic             err_ready;
  id_t              err_id_q;

  // address decode on offsets from each window base
  assign l2_off     = req_addr_i - addr_t'(`PULP_L2_BASE);
  assign periph_off = req_addr_i - addr_t'(`PULP_PERIPH_BASE);

  always_comb begin
    if (l2_off < L2_BYTES) begin
      req_route = ROUTE_L2;
    end else if (periph_off < PERIPH_BYTES) begin
      req_route = ROUTE_PERIPH;
    end else begin
      req_route = ROUTE_ERR;
    end
  end

  assign fifo_full  = (count_q == CNT_W'(DEPTH));
  assign fifo_empty = (count_q == '0);
  assign head       = fifo_q[rd_ptr_q];

  // request steering
  always_comb begin
    case (req_route)
      ROUTE_L2:     target_ready = l2_req_ready_i;
      ROUTE_PERIPH: target_ready = periph_req_ready_i;
      default:      target_ready = err_ready;
    endcase
  end

  assign req_ready_o        = !fifo_full && target_ready;
  assign push               = req_valid_i && req_ready_o;
  assign l2_req_valid_o     = req_valid_i && !fifo_full && (req_route == ROUTE_L2);
  assign periph_req_valid_o = req_valid_i && !fifo_full && (req_route == ROUTE_PERIPH);

  assign l2_req_we_o        = req_we_i;
  assign l2_req_addr_o      = req_addr_i;
  assign l2_req_wdata_o     = req_wdata_i;
  assign l2_req_strb_o      = req_strb_i;
  assign l2_req_id_o        = req_id_i;
  assign periph_req_we_o    = req_we_i;
  assign periph_req_addr_o  = req_addr_i;
  assign periph_req_wdata_o = req_wdata_i;
  assign periph_req_strb_o  = req_strb_i;
  assign periph_req_id_o    = req_id_i;

  // only the oldest target may answer the host
  always_comb begin
    sel_valid          = 1'b0;
    rsp_rdata_o        = '0;
    rsp_id_o           = err_id_q;
    rsp_err_o          = 1'b0;
    l2_rsp_ready_o     = 1'b0;
    periph_rsp_ready_o = 1'b0;
    case (head)
      ROUTE_L2: begin
        sel_valid      = l2_rsp_valid_i;
        rsp_rdata_o    = l2_rsp_rdata_i;
        rsp_id_o       = l2_rsp_id_i;
        l2_rsp_ready_o = rsp_ready_i && !fifo_empty;
      end
      ROUTE_PERIPH: begin
        sel_valid          = periph_rsp_valid_i;
        rsp_rdata_o        = periph_rsp_rdata_i;
        rsp_id_o           = periph_rsp_id_i;
        periph_rsp_ready_o = rsp_ready_i && !fifo_empty;
      end
      default: begin
        sel_valid = err_valid_q;
        rsp_err_o = 1'b1;
      end
    endcase
  end

  assign rsp_valid_o = sel_valid && !fifo_empty;
  assign pop         = rsp_valid_o && rsp_ready_i;

  // route order FIFO
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= req_route;
    end
  end

  // error responder, one entry
  assign err_ready = !err_valid_q || (pop && head == ROUTE_ERR);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_valid_q <= 1'b0;
    end else if (push && req_route == ROUTE_ERR) begin
      err_valid_q <= 1'b1;
    end else if (pop && head == ROUTE_ERR) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push && req_route == ROUTE_ERR) begin
      err_id_q <= req_id_i;
    end
  end

endmodule

// File: verilog/pulp.sv
// top level with SoC bus, L2 memory, width converter and peripherals
`timescale 1ns/100ps

module pulp import pulp_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  logic  req_we_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  input  strb_t req_strb_i,
  input  id_t   req_id_i,
  output logic  rsp_valid_o,
  input  logic  rsp_ready_i,
  output data_t rsp_rdata_o,
  output id_t   rsp_id_o,
  output logic  rsp_err_o
);

  // bus to L2
  logic         l2_req_valid;
  logic         l2_req_ready;
  logic         l2_req_we;
  addr_t        l2_req_addr;
  data_t        l2_req_wdata;
  strb_t        l2_req_strb;
  id_t          l2_req_id;
  logic         l2_rsp_valid;
  logic         l2_rsp_ready;
  data_t        l2_rsp_rdata;
  id_t          l2_rsp_id;
  // bus to width converter
  logic         periph_req_valid;
  logic         periph_req_ready;
  logic         periph_req_we;
  addr_t        periph_req_addr;
  data_t        periph_req_wdata;
  strb_t        periph_req_strb;
  id_t          periph_req_id;
  logic         periph_rsp_valid;
  logic         periph_rsp_ready;
  data_t        periph_rsp_rdata;
  id_t          periph_rsp_id;
  // width converter to registers
  logic         p_req_valid;
  logic         p_req_ready;
  logic         p_req_we;
  addr_t        p_req_addr;
  periph_data_t p_req_wdata;
  periph_strb_t p_req_strb;
  logic         p_rsp_valid;
  logic         p_rsp_ready;
  periph_data_t p_rsp_rdata;

  soc_bus i_soc_bus (
    .clk_i,
    .reset_i,
    .req_valid_i,
    .req_ready_o,
    .req_we_i,
    .req_addr_i,
    .req_wdata_i,
    .req_strb_i,
    .req_id_i,
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_rdata_o,
    .rsp_id_o,
    .rsp_err_o,
    .l2_req_valid_o     (l2_req_valid),
    .l2_req_ready_i     (l2_req_ready),
    .l2_req_we_o        (l2_req_we),
    .l2_req_addr_o      (l2_req_addr),
    .l2_req_wdata_o     (l2_req_wdata),
    .l2_req_strb_o      (l2_req_strb),
    .l2_req_id_o        (l2_req_id),
    .l2_rsp_valid_i     (l2_rsp_valid),
    .l2_rsp_ready_o     (l2_rsp_ready),
    .l2_rsp_rdata_i     (l2_rsp_rdata),
    .l2_rsp_id_i        (l2_rsp_id),
    .periph_req_valid_o (periph_req_valid),
    .periph_req_ready_i (periph_req_ready),
    .periph_req_we_o    (periph_req_we),
    .periph_req_addr_o  (periph_req_addr),
    .periph_req_wdata_o (periph_req_wdata),
    .periph_req_strb_o  (periph_req_strb),
    .periph_req_id_o    (periph_req_id),
    .periph_rsp_valid_i (periph_rsp_valid),
    .periph_rsp_ready_o (periph_rsp_ready),
    .periph_rsp_rdata_i (periph_rsp_rdata),
    .periph_rsp_id_i    (periph_rsp_id)
  );

  l2_mem i_l2_mem (
    .clk_i,
    .reset_i,
    .req_valid_i (l2_req_valid),
    .req_ready_o (l2_req_ready),
    .req_we_i    (l2_req_we),
    .req_addr_i  (l2_req_addr),
    .req_wdata_i (l2_req_wdata),
    .req_strb_i  (l2_req_strb),
    .req_id_i    (l2_req_id),
    .rsp_valid_o (l2_rsp_valid),
    .rsp_ready_i (l2_rsp_ready),
    .rsp_rdata_o (l2_rsp_rdata),
    .rsp_id_o    (l2_rsp_id)
  );

  periph_dwc i_periph_dwc (
    .clk_i,
    .reset_i,
    .req_valid_i   (periph_req_valid),
    .req_ready_o   (periph_req_ready),
    .req_we_i      (periph_req_we),
    .req_addr_i    (periph_req_addr),
    .req_wdata_i   (periph_req_wdata),
    .req_strb_i    (periph_req_strb),
    .req_id_i      (periph_req_id),
    .rsp_valid_o   (periph_rsp_valid),
    .rsp_ready_i   (periph_rsp_ready),
    .rsp_rdata_o   (periph_rsp_rdata),
    .rsp_id_o      (periph_rsp_id),
    .p_req_valid_o (p_req_valid),
    .p_req_ready_i (p_req_ready),
    .p_req_we_o    (p_req_we),
    .p_req_addr_o  (p_req_addr),
    .p_req_wdata_o (p_req_wdata),
    .p_req_strb_o  (p_req_strb),
    .p_rsp_valid_i (p_rsp_valid),
    .p_rsp_ready_o (p_rsp_ready),
    .p_rsp_rdata_i (p_rsp_rdata)
  );

  soc_peripherals i_periphs (
    .clk_i,
    .reset_i,
    .req_valid_i (p_req_valid),
    .req_ready_o (p_req_ready),
    .req_we_i    (p_req_we),
    .req_addr_i  (p_req_addr),
    .req_wdata_i (p_req_wdata),
    .req_strb_i  (p_req_strb),
    .rsp_valid_o (p_rsp_valid),
    .rsp_ready_i (p_rsp_ready),
    .rsp_rdata_o (p_rsp_rdata)
  );

endmodule

// File: tests/pulp_tb.sv
// testbench for the pulp top level with stimulus table, reference model and checks
`timescale 1ns/100ps
`include "pulp_params.svh"

module pulp_tb import pulp_pkg::*; ();

  typedef struct {
    int    test;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
    id_t   id;
    logic  err;
  } entry_t;

  typedef struct {
    int    test;
    data_t rdata;
    id_t   id;
    logic  err;
  } expect_t;

  localparam int    NUM_TESTS = 6;
  localparam logic  WR = 1'b1;
  localparam logic  RD = 1'b0;
  localparam logic  OK = 1'b0;
  localparam logic  ERR = 1'b1;
  localparam strb_t FULL = '1;
  localparam strb_t NONE = '0;
  localparam addr_t L2_BASE = addr_t'(`PULP_L2_BASE);
  localparam addr_t L2_SIZE = addr_t'(`PULP_L2_WORDS * 16);
  localparam addr_t P_BASE = addr_t'(`PULP_PERIPH_BASE);
  localparam addr_t P_SIZE = addr_t'(`PULP_PERIPH_REGS * 8);

  logic  clk_i;
  logic  reset_i;
  logic  req_valid_i;
  logic  req_ready_o;
  logic  req_we_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  strb_t req_strb_i;
  id_t   req_id_i;
  logic  rsp_valid_o;
  logic  rsp_ready_i;
  data_t rsp_rdata_o;
  id_t   rsp_id_o;
  logic  rsp_err_o;

  entry_t       table_q [$];
  expect_t      expect_q [$];
  data_t        ref_l2 [`PULP_L2_WORDS];
  periph_data_t ref_regs [`PULP_PERIPH_REGS];
  int           test_errors [1:NUM_TESTS];
  int           test_left [1:NUM_TESTS];
  string        test_name [1:NUM_TESTS];
  int           issue_idx = 0;
  int           done_cnt = 0;
  int           tests_passed = 0;
  int           tests_failed = 0;
  int           cycle_cnt = 0;
  int           cycle_limit = 0;

  pulp i_pulp (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // IDs count up with the table row so that order errors show
  task automatic add_entry(input int t, input logic we, input addr_t addr,
                           input data_t wdata, input strb_t strb, input logic err);
    entry_t e;
    e.test  = t;
    e.we    = we;
    e.addr  = addr;
    e.wdata = wdata;
    e.strb  = strb;
    e.id    = id_t'(table_q.size());
    e.err   = err;
    table_q.push_back(e);
    test_left[t]++;
  endtask

  function automatic logic in_window(addr_t a, addr_t base, addr_t size);
    addr_t off;
    off = a - base;
    return off < size;
  endfunction

  // reference model updated in acceptance order
  task automatic apply_model(input entry_t e, output expect_t x);
    int w;
    int r;
    x.test  = e.test;
    x.id    = e.id;
    x.err   = e.err;
    x.rdata = '0;
    if (in_window(e.addr, L2_BASE, L2_SIZE)) begin
      w = int'(e.addr[9:4]);
      if (e.we) begin
        for (int b = 0; b < 16; b++) begin
          if (e.strb[b]) begin
            ref_l2[w][b*8 +: 8] = e.wdata[b*8 +: 8];
          end
        end
      end else begin
        x.rdata = ref_l2[w];
      end
    end else if (in_window(e.addr, P_BASE, P_SIZE)) begin
      // low half is register 2k and high half 2k+1
      r = 2 * int'(e.addr[5:4]);
      if (e.we) begin
        for (int b = 0; b < 8; b++) begin
          if (e.strb[b]) begin
            ref_regs[r][b*8 +: 8] = e.wdata[b*8 +: 8];
          end
          if (e.strb[b+8]) begin
            ref_regs[r+1][b*8 +: 8] = e.wdata[64 + b*8 +: 8];
          end
        end
      end else begin
        x.rdata = {ref_regs[r+1], ref_regs[r]};
      end
    end
  endtask

  task automatic drive_request(input entry_t e);
    req_valid_i = 1'b1;
    req_we_i    = e.we;
    req_addr_i  = e.addr;
    req_wdata_i = e.wdata;
    req_strb_i  = e.strb;
    req_id_i    = e.id;
  endtask

  task automatic report_test(input int t);
    if (test_errors[t] == 0) begin
      tests_passed++;
      $display("test %0d %s: pass", t, test_name[t]);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail with %0d errors", t, test_name[t], test_errors[t]);
    end
  endtask

  task automatic check_response();
    expect_t x;
    assert (expect_q.size() > 0) else begin
      $display("response with id %h arrived with no request outstanding", rsp_id_o);
      test_errors[6]++;
    end
    if (expect_q.size() > 0) begin
      x = expect_q.pop_front();
      assert (rsp_id_o == x.id) else begin
        $display("Mismatch rsp_id_o: got %h expected %h", rsp_id_o, x.id);
        test_errors[x.test]++;
      end
      assert (rsp_err_o == x.err) else begin
        $display("Mismatch rsp_err_o: got %h expected %h", rsp_err_o, x.err);
        test_errors[x.test]++;
      end
      assert (rsp_rdata_o == x.rdata) else begin
        $display("Mismatch rsp_rdata_o: got %h expected %h", rsp_rdata_o, x.rdata);
        test_errors[x.test]++;
      end
      done_cnt++;
      test_left[x.test]--;
      if (test_left[x.test] == 0 && x.test != 6) begin
        report_test(x.test);
      end
    end
  endtask

  // run limit from the table length
  initial begin
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("run timed out after %0d cycles", cycle_cnt);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    expect_t x;
    void'($urandom(69948));
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_strb_i  = '0;
    req_id_i    = '0;
    rsp_ready_i = 1'b0;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      test_errors[t] = 0;
      test_left[t]   = 0;
    end
    test_name[1] = "reset state";
    test_name[2] = "l2 full word";
    test_name[3] = "l2 partial strobe";
    test_name[4] = "peripheral width converter";
    test_name[5] = "unmapped address";
    test_name[6] = "mixed back to back";

    // test, we, addr, wdata, strb, err
    add_entry(2, WR, 32'h0000_0000, {4{32'h0123_4567}}, FULL, OK);
    add_entry(2, WR, 32'h0000_0010, {4{32'h89ab_cdef}}, FULL, OK);
    add_entry(2, WR, 32'h0000_03f0, {4{32'hdead_beef}}, FULL, OK);
    add_entry(2, RD, 32'h0000_0000, '0, NONE, OK);
    add_entry(2, RD, 32'h0000_03f0, '0, NONE, OK);
    add_entry(2, RD, 32'h0000_0010, '0, NONE, OK);
    add_entry(3, WR, 32'h0000_0020, {4{32'h1111_1111}}, FULL, OK);
    add_entry(3, WR, 32'h0000_0020, {4{32'heedd_ccbb}}, 16'h00f0, OK);
    add_entry(3, WR, 32'h0000_0020, {4{32'h7766_5544}}, 16'h8001, OK);
    add_entry(3, RD, 32'h0000_0020, '0, NONE, OK);
    add_entry(3, WR, 32'h0000_0010, {4{32'h5a5a_5a5a}}, 16'hff00, OK);
    add_entry(3, RD, 32'h0000_0010, '0, NONE, OK);
    add_entry(4, WR, 32'h1000_0000, {4{32'h0bad_f00d}}, FULL, OK);
    add_entry(4, WR, 32'h1000_0010, {4{32'hcafe_babe}}, FULL, OK);
    add_entry(4, RD, 32'h1000_0000, '0, NONE, OK);
    add_entry(4, RD, 32'h1000_0010, '0, NONE, OK);
    add_entry(4, WR, 32'h1000_0010, {4{32'h1234_5678}}, 16'h0f0f, OK);
    add_entry(4, RD, 32'h1000_0010, '0, NONE, OK);
    add_entry(4, WR, 32'h1000_0030, {4{32'hfeed_face}}, FULL, OK);
    add_entry(4, WR, 32'h1000_0030, {4{32'h0000_0000}}, 16'hc003, OK);
    add_entry(4, RD, 32'h1000_0030, '0, NONE, OK);
    // just past each window where word 0 and registers 0/1 would alias
    add_entry(5, WR, 32'h0000_0400, {4{32'hffff_ffff}}, FULL, ERR);
    add_entry(5, WR, 32'h1000_0040, {4{32'hffff_ffff}}, FULL, ERR);
    add_entry(5, RD, 32'h2000_0000, '0, NONE, ERR);
    add_entry(5, RD, 32'h0fff_fff0, '0, NONE, ERR);
    add_entry(5, RD, 32'h0000_0000, '0, NONE, OK);
    add_entry(5, RD, 32'h1000_0000, '0, NONE, OK);
    add_entry(6, WR, 32'h0000_0030, {4{32'h3030_3030}}, FULL, OK);
    add_entry(6, WR, 32'h1000_0020, {4{32'h2020_2020}}, FULL, OK);
    add_entry(6, RD, 32'h8000_0000, '0, NONE, ERR);
    add_entry(6, RD, 32'h0000_0030, '0, NONE, OK);
    add_entry(6, RD, 32'h1000_0020, '0, NONE, OK);
    add_entry(6, WR, 32'h0000_0500, {4{32'h5555_aaaa}}, FULL, ERR);
    add_entry(6, RD, 32'h0000_0000, '0, NONE, OK);
    add_entry(6, RD, 32'h1000_0010, '0, NONE, OK);
    add_entry(6, WR, 32'h0000_0030, {4{32'h0f0f_0f0f}}, 16'h5555, OK);
    add_entry(6, RD, 32'h0000_0030, '0, NONE, OK);
    add_entry(6, RD, 32'hffff_fff0, '0, NONE, ERR);
    add_entry(6, RD, 32'h0000_03f0, '0, NONE, OK);
    cycle_limit = 16 + 40 * table_q.size();

    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    @(negedge clk_i);
    assert (rsp_valid_o == 1'b0) else begin
      $display("Mismatch rsp_valid_o: got %h expected %h", rsp_valid_o, 1'b0);
      test_errors[1]++;
    end
    assert (req_ready_o == 1'b1) else begin
      $display("Mismatch req_ready_o: got %h expected %h", req_ready_o, 1'b1);
      test_errors[1]++;
    end
    report_test(1);

    // issue in order and accept responses under random backpressure
    while (done_cnt < table_q.size()) begin
      @(posedge clk_i);
      #1;
      if (issue_idx < table_q.size()) begin
        drive_request(table_q[issue_idx]);
      end else begin
        req_valid_i = 1'b0;
      end
      rsp_ready_i = ($urandom % 4) != 0;
      @(negedge clk_i);
      if (req_valid_i && req_ready_o) begin
        apply_model(table_q[issue_idx], x);
        expect_q.push_back(x);
        issue_idx++;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        check_response();
      end
    end

    // nothing may follow the last response
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      assert (rsp_valid_o == 1'b0) else begin
        $display("extra response with id %h after all requests completed", rsp_id_o);
        test_errors[6]++;
      end
    end
    report_test(6);

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+verilog
verilog/pulp_pkg.sv
verilog/l2_mem.sv
verilog/periph_dwc.sv
verilog/soc_peripherals.sv
verilog/soc_bus.sv
verilog/pulp.sv
tests/pulp_tb.sv

// File: Makefile
# Verilator build and run of the pulp testbench

VERILATOR ?= verilator
TOP       ?= pulp_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
